//--- design/nipcb_pkg.sv
package nipcb_pkg;

	// Bus geometry
	localparam int DATA_WIDTH = 32;
	localparam int DATA_BYTES = DATA_WIDTH / 8;
	localparam int ADDR_W = 8;

	// Register window
	localparam int REG_COUNT = 11;
	localparam int REG_IDX_W = 4;

	// Electrode side
	localparam int MAG_W = 16;
	localparam int CH_COUNT = 4;
	localparam int CH_W = $clog2(CH_COUNT);

	// Word index of each register
	localparam logic [REG_IDX_W-1:0] REG_TRIG = 4'd0;
	localparam logic [REG_IDX_W-1:0] REG_FLAGS = 4'd1;
	localparam logic [REG_IDX_W-1:0] REG_CONF = 4'd2;
	localparam logic [REG_IDX_W-1:0] REG_CH_SEL = 4'd3;
	localparam logic [REG_IDX_W-1:0] REG_CYC_HIGH = 4'd4;
	localparam logic [REG_IDX_W-1:0] REG_CYC_LOW = 4'd5;
	localparam logic [REG_IDX_W-1:0] REG_CYC_DELAY = 4'd6;
	localparam logic [REG_IDX_W-1:0] REG_CYC_STALL = 4'd7;
	localparam logic [REG_IDX_W-1:0] REG_CYC_COUNT = 4'd8;
	localparam logic [REG_IDX_W-1:0] REG_MAG_HIGH = 4'd9;
	localparam logic [REG_IDX_W-1:0] REG_MAG_LOW = 4'd10;

	typedef struct packed {
		logic [DATA_WIDTH-2:0] reserved;
		logic stim_start;
	} nipcb_trig_s;

	// Parameter registers take the raw word, REG_TRIG takes the bit view
	typedef union packed {
		logic [DATA_WIDTH-1:0] raw;
		nipcb_trig_s trig;
	} nipcb_wdata_u;

	typedef struct packed {
		logic valid;
		logic [REG_IDX_W-1:0] index;
		logic [DATA_BYTES-1:0] strb;
		nipcb_wdata_u data;
	} nipcb_reg_wr_s;

	typedef struct packed {
		logic [CH_W-1:0] channel;
		logic [DATA_WIDTH-1:0] cycles_high;
		logic [DATA_WIDTH-1:0] cycles_low;
		logic [DATA_WIDTH-1:0] cycles_delay;
		logic [DATA_WIDTH-1:0] cycles_stall;
		logic [DATA_WIDTH-1:0] pulse_count;
		logic [MAG_W-1:0] mag_high;
		logic [MAG_W-1:0] mag_low;
	} nipcb_stim_cfg_s;

	typedef struct packed {
		logic [CH_COUNT-1:0] en;
		logic [MAG_W-1:0] mag;
	} nipcb_stim_out_s;

endpackage

//--- design/nipcb_ahb_ctrl.sv
`timescale 1ns/1ns

module nipcb_ahb_ctrl #(
	parameter int unsigned ADDR_BASE = 0
) (
	input logic HCLK,
	input logic HRESETn,

	input logic HSEL,
	input logic [nipcb_pkg::ADDR_W-1:0] HADDR,
	input logic [1:0] HTRANS,
	input logic [2:0] HSIZE,
	input logic HWRITE,
	input logic [nipcb_pkg::DATA_WIDTH-1:0] HWDATA,
	input logic HREADY,
	output logic [nipcb_pkg::DATA_WIDTH-1:0] HRDATA,
	output logic HREADYOUT,
	output logic HRESP,

	output nipcb_pkg::nipcb_reg_wr_s reg_wr,
	output logic [nipcb_pkg::REG_IDX_W-1:0] rd_index,
	input logic [nipcb_pkg::DATA_WIDTH-1:0] rd_data
);
	import nipcb_pkg::*;

	localparam logic [2:0] SIZE_BYTE = 3'b000;
	localparam logic [2:0] SIZE_HALF = 3'b001;
	localparam logic [2:0] SIZE_WORD = 3'b010;
	localparam logic RESP_OKAY = 1'b0;
	localparam logic RESP_ERROR = 1'b1;
	localparam int unsigned WIN_BYTES = REG_COUNT * DATA_BYTES;

	// Address phase
	logic accept;
	logic [31:0] addr_ext;
	logic [31:0] offset;
	logic [REG_IDX_W-1:0] idx;
	logic in_range;
	logic bad;
	logic [DATA_BYTES-1:0] strb;

	// Data phase
	logic dp_read;
	logic dp_write;
	logic err_first;
	logic err_second;
	logic [REG_IDX_W-1:0] dp_idx;
	logic [DATA_BYTES-1:0] dp_strb;

	// NONSEQ or SEQ both have HTRANS[1] set
	assign accept = HSEL && HTRANS[1] && HREADY;

	assign addr_ext = 32'(HADDR);
	assign offset = addr_ext - ADDR_BASE;
	assign idx = offset[REG_IDX_W+1:2];
	assign in_range = (addr_ext >= ADDR_BASE) && (addr_ext < ADDR_BASE + WIN_BYTES);

	assign bad = !in_range || (HSIZE > SIZE_WORD) || (HWRITE && idx == REG_FLAGS);

	// Lane select from size and low address bits
	always_comb begin
		case (HSIZE)
			SIZE_BYTE: strb = 4'b0001 << HADDR[1:0];
			SIZE_HALF: strb = HADDR[1] ? 4'b1100 : 4'b0011;
			default: strb = 4'b1111;
		endcase
	end

	always_ff @(posedge HCLK) begin
		if (!HRESETn) begin
			dp_read <= 1'b0;
			dp_write <= 1'b0;
			err_first <= 1'b0;
			err_second <= 1'b0;
		end else begin
			dp_read <= accept && !bad && !HWRITE;
			dp_write <= accept && !bad && HWRITE;
			err_first <= accept && bad;
			err_second <= err_first;
		end
	end

	always_ff @(posedge HCLK) begin
		if (accept) begin
			dp_idx <= idx;
			dp_strb <= strb;
		end
	end

	// Error takes one wait cycle, then completes
	assign HREADYOUT = !err_first;
	assign HRESP = (err_first || err_second) ? RESP_ERROR : RESP_OKAY;

	// Read data comes straight from the bank in the data phase
	assign rd_index = dp_idx;
	assign HRDATA = dp_read ? rd_data : '0;

	always_comb begin
		reg_wr.valid = dp_write;
		reg_wr.index = dp_idx;
		reg_wr.strb = dp_strb;
		reg_wr.data.raw = HWDATA;
	end

	a_err_two_cycle: assert property (@(posedge HCLK) disable iff (!HRESETn)
		(HRESP == RESP_ERROR && !HREADYOUT) |=> (HRESP == RESP_ERROR && HREADYOUT))
		else $error("ERROR response not completed in second cycle");

	a_no_write_on_err: assert property (@(posedge HCLK) disable iff (!HRESETn)
		!(reg_wr.valid && HRESP == RESP_ERROR))
		else $error("Register write during ERROR response");

endmodule

//--- design/nipcb_reg_bank.sv
`timescale 1ns/1ns

module nipcb_reg_bank (
	input logic HCLK,
	input logic HRESETn,

	input nipcb_pkg::nipcb_reg_wr_s reg_wr,
	input logic [nipcb_pkg::REG_IDX_W-1:0] rd_index,
	output logic [nipcb_pkg::DATA_WIDTH-1:0] rd_data,

	input logic running,
	output logic stim_start,
	output nipcb_pkg::nipcb_stim_cfg_s stim_cfg
);
	import nipcb_pkg::*;

	// Storage for REG_CONF up to REG_MAG_LOW
	logic [DATA_WIDTH-1:0] regs [REG_CONF:REG_MAG_LOW];

	logic wr_param;
	logic trig_wr;
	logic enable;
	logic [DATA_WIDTH-1:0] wr_mask;

	// Bits that exist in each register, the rest read as zero
	function automatic logic [DATA_WIDTH-1:0] impl_mask(input logic [REG_IDX_W-1:0] idx);
		case (idx)
			REG_CONF: impl_mask = {{(DATA_WIDTH-1){1'b0}}, 1'b1};
			REG_CH_SEL: impl_mask = {{(DATA_WIDTH-CH_W){1'b0}}, {CH_W{1'b1}}};
			REG_MAG_HIGH,
			REG_MAG_LOW: impl_mask = {{(DATA_WIDTH-MAG_W){1'b0}}, {MAG_W{1'b1}}};
			default: impl_mask = '1;
		endcase
	endfunction

	assign wr_param = reg_wr.valid && (reg_wr.index >= REG_CONF) &&
		(reg_wr.index <= REG_MAG_LOW);
	assign wr_mask = impl_mask(reg_wr.index);

	always_ff @(posedge HCLK) begin
		if (!HRESETn) begin
			for (int i = REG_CONF; i <= REG_MAG_LOW; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_param) begin
			for (int b = 0; b < DATA_BYTES; b++) begin
				if (reg_wr.strb[b]) begin
					regs[reg_wr.index][b*8 +: 8] <= reg_wr.data.raw[b*8 +: 8] & wr_mask[b*8 +: 8];
				end
			end
		end
	end

	// Trigger bit sits in lane 0
	assign trig_wr = reg_wr.valid && (reg_wr.index == REG_TRIG) && reg_wr.strb[0] &&
		reg_wr.data.trig.stim_start;
	assign enable = regs[REG_CONF][0];

	always_ff @(posedge HCLK) begin
		if (!HRESETn) begin
			stim_start <= 1'b0;
		end else begin
			stim_start <= trig_wr && enable && !running;
		end
	end

	always_comb begin
		rd_data = '0;
		if (rd_index == REG_FLAGS) begin
			rd_data[0] = running;
		end else if (rd_index >= REG_CONF && rd_index <= REG_MAG_LOW) begin
			rd_data = regs[rd_index];
		end
	end

	always_comb begin
		stim_cfg.channel = regs[REG_CH_SEL][CH_W-1:0];
		stim_cfg.cycles_high = regs[REG_CYC_HIGH];
		stim_cfg.cycles_low = regs[REG_CYC_LOW];
		stim_cfg.cycles_delay = regs[REG_CYC_DELAY];
		stim_cfg.cycles_stall = regs[REG_CYC_STALL];
		stim_cfg.pulse_count = regs[REG_CYC_COUNT];
		stim_cfg.mag_high = regs[REG_MAG_HIGH][MAG_W-1:0];
		stim_cfg.mag_low = regs[REG_MAG_LOW][MAG_W-1:0];
	end

endmodule

//--- design/nipcb_stim_sequencer.sv
`timescale 1ns/1ns

module nipcb_stim_sequencer (
	input logic HCLK,
	input logic HRESETn,

	input logic stim_start,
	input nipcb_pkg::nipcb_stim_cfg_s stim_cfg,
	output logic running,
	output nipcb_pkg::nipcb_stim_out_s stim_out
);
	import nipcb_pkg::*;

	localparam logic [2:0] ST_IDLE = 3'd0;
	localparam logic [2:0] ST_DELAY = 3'd1;
	localparam logic [2:0] ST_HIGH = 3'd2;
	localparam logic [2:0] ST_LOW = 3'd3;
	localparam logic [2:0] ST_STALL = 3'd4;

	logic [2:0] state;
	logic [DATA_WIDTH-1:0] phase_cnt;
	logic [DATA_WIDTH-1:0] pulse_left;
	logic phase_done;
	nipcb_stim_cfg_s cfg_q;

	// Index of the last cycle, zero treated as one
	function automatic logic [DATA_WIDTH-1:0] last_of(input logic [DATA_WIDTH-1:0] n);
		last_of = (n == '0) ? '0 : n - 1'b1;
	endfunction

	assign phase_done = (phase_cnt == '0);
	assign running = (state != ST_IDLE);

	// Settings frozen for the length of a sequence
	always_ff @(posedge HCLK) begin
		if (state == ST_IDLE) begin
			cfg_q <= stim_cfg;
		end
	end

	always_ff @(posedge HCLK) begin
		if (!HRESETn) begin
			state <= ST_IDLE;
			phase_cnt <= '0;
			pulse_left <= '0;
		end else if (state != ST_IDLE && !phase_done) begin
			phase_cnt <= phase_cnt - 1'b1;
		end else begin
			case (state)
				ST_IDLE: begin
					if (stim_start) begin
						pulse_left <= last_of(stim_cfg.pulse_count);
						if (stim_cfg.cycles_delay != '0) begin
							state <= ST_DELAY;
							phase_cnt <= stim_cfg.cycles_delay - 1'b1;
						end else begin
							state <= ST_HIGH;
							phase_cnt <= last_of(stim_cfg.cycles_high);
						end
					end
				end
				ST_DELAY: begin
					state <= ST_HIGH;
					phase_cnt <= last_of(cfg_q.cycles_high);
				end
				ST_HIGH: begin
					state <= ST_LOW;
					phase_cnt <= last_of(cfg_q.cycles_low);
				end
				ST_LOW: begin
					if (cfg_q.cycles_stall != '0) begin
						state <= ST_STALL;
						phase_cnt <= cfg_q.cycles_stall - 1'b1;
					end else if (pulse_left == '0) begin
						state <= ST_IDLE;
					end else begin
						pulse_left <= pulse_left - 1'b1;
						state <= ST_HIGH;
						phase_cnt <= last_of(cfg_q.cycles_high);
					end
				end
				ST_STALL: begin
					if (pulse_left == '0) begin
						state <= ST_IDLE;
					end else begin
						pulse_left <= pulse_left - 1'b1;
						state <= ST_HIGH;
						phase_cnt <= last_of(cfg_q.cycles_high);
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Electrode drive only in the two active phases
	always_comb begin
		stim_out = '0;
		if (state == ST_HIGH || state == ST_LOW) begin
			stim_out.en = {{(CH_COUNT-1){1'b0}}, 1'b1} << cfg_q.channel;
			stim_out.mag = (state == ST_HIGH) ? cfg_q.mag_high : cfg_q.mag_low;
		end
	end

	// Channel stays put for the whole sequence
	a_en_stable: assert property (@(posedge HCLK) disable iff (!HRESETn)
		(stim_out.en != '0) |=> (stim_out.en == '0 || stim_out.en == $past(stim_out.en)))
		else $error("Channel enable changed during a sequence");

endmodule

//--- design/nipcb_top.sv
`timescale 1ns/1ns

module nipcb_top #(
	parameter int unsigned ADDR_BASE = 0
) (
	input logic HCLK,
	input logic HRESETn,

	input logic HSEL,
	input logic [nipcb_pkg::ADDR_W-1:0] HADDR,
	input logic [1:0] HTRANS,
	input logic [2:0] HSIZE,
	input logic HWRITE,
	input logic [nipcb_pkg::DATA_WIDTH-1:0] HWDATA,
	input logic HREADY,
	output logic [nipcb_pkg::DATA_WIDTH-1:0] HRDATA,
	output logic HREADYOUT,
	output logic HRESP,

	output nipcb_pkg::nipcb_stim_out_s stim_out
);
	import nipcb_pkg::*;

	nipcb_reg_wr_s reg_wr;
	logic [REG_IDX_W-1:0] rd_index;
	logic [DATA_WIDTH-1:0] rd_data;
	nipcb_stim_cfg_s stim_cfg;
	logic stim_start;
	logic running;

	nipcb_ahb_ctrl #(
		.ADDR_BASE (ADDR_BASE)
	) i_ahb_ctrl (
		.HCLK (HCLK),
		.HRESETn (HRESETn),
		.HSEL (HSEL),
		.HADDR (HADDR),
		.HTRANS (HTRANS),
		.HSIZE (HSIZE),
		.HWRITE (HWRITE),
		.HWDATA (HWDATA),
		.HREADY (HREADY),
		.HRDATA (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP (HRESP),
		.reg_wr (reg_wr),
		.rd_index (rd_index),
		.rd_data (rd_data)
	);

	nipcb_reg_bank i_reg_bank (
		.HCLK (HCLK),
		.HRESETn (HRESETn),
		.reg_wr (reg_wr),
		.rd_index (rd_index),
		.rd_data (rd_data),
		.running (running),
		.stim_start (stim_start),
		.stim_cfg (stim_cfg)
	);

	nipcb_stim_sequencer i_stim_sequencer (
		.HCLK (HCLK),
		.HRESETn (HRESETn),
		.stim_start (stim_start),
		.stim_cfg (stim_cfg),
		.running (running),
		.stim_out (stim_out)
	);

endmodule

//--- dv/tb_nipcb.sv
`timescale 1ns/1ns

module tb_nipcb;
	import nipcb_pkg::*;

	localparam int HALF_PERIOD = 10;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_LINES = 64;

	logic HCLK = 1'b0;
	logic HRESETn;
	logic HSEL;
	logic [ADDR_W-1:0] HADDR;
	logic [1:0] HTRANS;
	logic [2:0] HSIZE;
	logic HWRITE;
	logic [DATA_WIDTH-1:0] HWDATA;
	logic HREADY;
	logic [DATA_WIDTH-1:0] HRDATA;
	logic HREADYOUT;
	logic HRESP;
	nipcb_stim_out_s stim_out;

	// One entry per line of the input file
	string t_name [MAX_LINES];
	string t_op [MAX_LINES];
	logic [31:0] t_addr [MAX_LINES];
	logic [31:0] t_size [MAX_LINES];
	logic [31:0] t_data [MAX_LINES];
	logic [31:0] t_resp [MAX_LINES];
	logic [31:0] t_value [MAX_LINES];
	int n_lines = 0;
	int max_dur = 0;
	int errors = 0;
	integer seed = 67708;
	logic limit_ready = 1'b0;

	// Electrode monitor state
	logic mon_on = 1'b0;
	logic [CH_COUNT-1:0] mon_en;
	logic [MAG_W-1:0] mon_hi;
	logic [MAG_W-1:0] mon_lo;
	int hi_cnt;
	int lo_cnt;
	int bad_cnt;

	nipcb_top #(.ADDR_BASE(0)) i_dut (.*);

	always #HALF_PERIOD HCLK = ~HCLK;

	always @(negedge HCLK) begin
		if (mon_on && stim_out.en != '0) begin
			if (stim_out.en == mon_en && stim_out.mag == mon_hi) begin
				hi_cnt++;
			end else if (stim_out.en == mon_en && stim_out.mag == mon_lo) begin
				lo_cnt++;
			end else begin
				bad_cnt++;
			end
		end else if (mon_on && stim_out.mag != '0) begin
			// No magnitude without a channel
			bad_cnt++;
		end
	end

	function automatic int at_least_one(input logic [7:0] n);
		return (n == 0) ? 1 : int'(n);
	endfunction

	// p packs {count, stall, low, high} one byte each
	function automatic int sequence_cycles(input logic [31:0] p, input logic [31:0] delay);
		return int'(delay) + at_least_one(p[31:24]) *
			(at_least_one(p[7:0]) + at_least_one(p[15:8]) + int'(p[23:16]));
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		errors++;
		$display("[ERROR] %s: expected 0x%h, actual 0x%h", name, exp, act);
	endtask

	// kind is 0 for OKAY, 1 for a proper two-cycle ERROR, 2 for anything else
	task automatic bus_xfer(input logic write, input logic [31:0] addr, input logic [2:0] size,
		input logic [31:0] wdata, output logic [31:0] kind, output logic [31:0] rdata);
		HSEL = 1'b1;
		HTRANS = 2'b10;
		HADDR = addr[ADDR_W-1:0];
		HSIZE = size;
		HWRITE = write;
		@(posedge HCLK);
		#1;
		HSEL = 1'b0;
		HTRANS = 2'b00;
		HWDATA = wdata;
		@(negedge HCLK);
		if (HREADYOUT && !HRESP) begin
			kind = 0;
		end else if (!HREADYOUT && HRESP) begin
			@(negedge HCLK);
			kind = (HREADYOUT && HRESP) ? 1 : 2;
		end else begin
			kind = 2;
		end
		rdata = HRDATA;
		@(posedge HCLK);
		#1;
	endtask

	task automatic write_reg(input string name, input logic [REG_IDX_W-1:0] idx,
		input logic [31:0] data);
		logic [31:0] kind;
		logic [31:0] rdata;
		bus_xfer(1'b1, 32'(idx) << 2, 3'd2, data, kind, rdata);
		if (kind != 0) begin
			report_mismatch({name, " write response"}, 0, kind);
		end
	endtask

	task automatic read_reg(input string name, input logic [REG_IDX_W-1:0] idx,
		output logic [31:0] data);
		logic [31:0] kind;
		bus_xfer(1'b0, 32'(idx) << 2, 3'd2, 32'd0, kind, data);
		if (kind != 0) begin
			report_mismatch({name, " read response"}, 0, kind);
		end
	endtask

	task automatic load_tests();
		int fd;
		string line;
		string nm;
		string op;
		logic [31:0] a;
		logic [31:0] sz;
		logic [31:0] d;
		logic [31:0] r;
		logic [31:0] v;
		fd = $fopen("dv/nipcb_input.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Cannot open the stimulus file dv/nipcb_input.txt");
			return;
		end
		while (!$feof(fd) && n_lines < MAX_LINES) begin
			line = "";
			if ($fgets(line, fd) == 0 || line.len() < 2 || line[0] == "#") begin
				continue;
			end
			if ($sscanf(line, "%s %s %h %h %h %h %h", nm, op, a, sz, d, r, v) != 7) begin
				continue;
			end
			// Zero parameters on an S line ask for random ones
			if (op == "S" && d == 0) begin
				d[31:24] = 2 + {$random(seed)} % 4;
				d[23:16] = {$random(seed)} % 8;
				d[15:8] = 2 + {$random(seed)} % 8;
				d[7:0] = 2 + {$random(seed)} % 8;
				r = {$random(seed)} % 8;
				v = {$random(seed)};
				if (v[31:16] == v[15:0]) begin
					v[15:0] = ~v[15:0];
				end
			end
			if (op == "S" && sequence_cycles(d, r) > max_dur) begin
				max_dur = sequence_cycles(d, r);
			end
			t_name[n_lines] = nm;
			t_op[n_lines] = op;
			t_addr[n_lines] = a;
			t_size[n_lines] = sz;
			t_data[n_lines] = d;
			t_resp[n_lines] = r;
			t_value[n_lines] = v;
			n_lines++;
		end
		$fclose(fd);
	endtask

	task automatic run_sequence(input int i);
		logic [31:0] p;
		logic [31:0] flags;
		logic [31:0] trig_rd;
		logic en;
		int exp_hi;
		int exp_lo;
		int dur;
		int polls;
		p = t_data[i];
		en = t_size[i][0];
		dur = sequence_cycles(p, t_resp[i]);
		exp_hi = en ? at_least_one(p[31:24]) * at_least_one(p[7:0]) : 0;
		exp_lo = en ? at_least_one(p[31:24]) * at_least_one(p[15:8]) : 0;
		write_reg(t_name[i], REG_CONF, {31'd0, en});
		write_reg(t_name[i], REG_CH_SEL, t_addr[i]);
		write_reg(t_name[i], REG_CYC_HIGH, p[7:0]);
		write_reg(t_name[i], REG_CYC_LOW, p[15:8]);
		write_reg(t_name[i], REG_CYC_STALL, p[23:16]);
		write_reg(t_name[i], REG_CYC_COUNT, p[31:24]);
		write_reg(t_name[i], REG_CYC_DELAY, t_resp[i]);
		write_reg(t_name[i], REG_MAG_HIGH, t_value[i][31:16]);
		write_reg(t_name[i], REG_MAG_LOW, t_value[i][15:0]);
		mon_en = {{(CH_COUNT-1){1'b0}}, 1'b1} << t_addr[i][CH_W-1:0];
		mon_hi = t_value[i][31:16];
		mon_lo = t_value[i][15:0];
		hi_cnt = 0;
		lo_cnt = 0;
		bad_cnt = 0;
		mon_on = 1'b1;
		write_reg(t_name[i], REG_TRIG, 32'd1);
		read_reg(t_name[i], REG_FLAGS, flags);
		if (flags != {31'd0, en}) begin
			report_mismatch({t_name[i], " running flag"}, {31'd0, en}, flags);
		end
		read_reg(t_name[i], REG_TRIG, trig_rd);
		if (trig_rd != 0) begin
			report_mismatch({t_name[i], " trigger readback"}, 0, trig_rd);
		end
		// Retrigger while busy, long sequences only
		if (en && dur >= 8) begin
			write_reg(t_name[i], REG_TRIG, 32'd1);
		end
		if (!en) begin
			repeat (dur) @(posedge HCLK);
			#1;
		end
		polls = 0;
		read_reg(t_name[i], REG_FLAGS, flags);
		while (flags != 0 && polls < dur + 8) begin
			read_reg(t_name[i], REG_FLAGS, flags);
			polls++;
		end
		if (flags != 0) begin
			errors++;
			$display("%s: running flag still set after %0d polls", t_name[i], polls);
		end
		mon_on = 1'b0;
		if (hi_cnt != exp_hi) begin
			report_mismatch({t_name[i], " high cycles"}, exp_hi, hi_cnt);
		end
		if (lo_cnt != exp_lo) begin
			report_mismatch({t_name[i], " low cycles"}, exp_lo, lo_cnt);
		end
		if (bad_cnt != 0) begin
			report_mismatch({t_name[i], " wrong drive cycles"}, 0, bad_cnt);
		end
		if (stim_out != '0) begin
			report_mismatch({t_name[i], " stim_out after end"}, 0, stim_out);
		end
	endtask

	task automatic run_line(input int i);
		logic [31:0] kind;
		logic [31:0] rdata;
		if (t_op[i] == "S") begin
			run_sequence(i);
		end else begin
			bus_xfer(t_op[i] == "W", t_addr[i], t_size[i][2:0], t_data[i], kind, rdata);
			if (kind != t_resp[i]) begin
				report_mismatch({t_name[i], " response"}, t_resp[i], kind);
			end
			if (t_op[i] == "R" && rdata != t_value[i]) begin
				report_mismatch(t_name[i], t_value[i], rdata);
			end
		end
	endtask

	initial begin
		longint limit;
		wait (limit_ready);
		limit = longint'(RESET_CYCLES + n_lines * (60 + 3 * max_dur)) * 2 * HALF_PERIOD;
		#(limit);
		errors++;
		$display("Watchdog expired after %0d ns with tests still running", limit);
		$display("Done: %0d lines, %0d errors", n_lines, errors);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		HRESETn = 1'b0;
		HSEL = 1'b0;
		HADDR = '0;
		HTRANS = 2'b00;
		HSIZE = 3'd0;
		HWRITE = 1'b0;
		HWDATA = '0;
		HREADY = 1'b1;
		load_tests();
		if (n_lines == 0) begin
			errors++;
			$display("No test lines were read from the input file");
		end
		limit_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge HCLK);
		#1;
		HRESETn = 1'b1;
		@(negedge HCLK);
		if ({HREADYOUT, HRESP} != 2'b10) begin
			report_mismatch("reset response", 32'd2, {HREADYOUT, HRESP});
		end
		if (HRDATA != '0) begin
			report_mismatch("reset HRDATA", 0, HRDATA);
		end
		if (stim_out != '0) begin
			report_mismatch("reset stim_out", 0, stim_out);
		end
		@(posedge HCLK);
		#1;
		for (int i = 0; i < n_lines; i++) begin
			run_line(i);
		end
		$display("Done: %0d lines, %0d errors", n_lines, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- verilog.f
design/nipcb_pkg.sv
design/nipcb_ahb_ctrl.sv
design/nipcb_reg_bank.sv
design/nipcb_stim_sequencer.sv
design/nipcb_top.sv
dv/tb_nipcb.sv

//--- dv/nipcb_input.txt
# name op addr size data resp value (hex). W checks resp; R checks resp and read word value
# S: addr=channel size=enable data={count,stall,low,high} resp=delay value={mag_high,mag_low}
# S with data 0 draws its sequence parameters from $random
wr_high W 10 2 12345678 0 0
rd_high R 10 2 0 0 12345678
wr_stall W 1c 2 deadbeef 0 0
rd_stall R 1c 2 0 0 deadbeef
wr_mag_high W 24 2 ffff1234 0 0
rd_mag_high R 24 2 0 0 00001234
wr_ch_sel W 0c 2 ffffffff 0 0
rd_ch_sel R 0c 2 0 0 00000003
wr_conf W 08 2 ffffffff 0 0
rd_conf R 08 2 0 0 00000001
wr_trig_zero W 00 2 00000000 0 0
rd_trig R 00 2 0 0 00000000
rd_flags R 04 2 0 0 00000000
wr_byte0 W 10 0 000000aa 0 0
rd_byte0 R 10 2 0 0 123456aa
wr_half1 W 12 1 cafe0000 0 0
rd_half1 R 10 2 0 0 cafe56aa
wr_byte3 W 13 0 77000000 0 0
rd_byte3 R 10 2 0 0 77fe56aa
wr_mag_half1 W 26 1 ffff0000 0 0
rd_mag_half1 R 24 2 0 0 00001234
wr_mag_byte1 W 25 0 0000ab00 0 0
rd_mag_byte1 R 24 2 0 0 0000ab34
err_wr_range W 2c 2 11111111 1 0
err_rd_far R fc 2 0 1 00000000
err_wr_flags W 04 2 00000001 1 0
rd_flags_after R 04 2 0 0 00000000
err_wr_size W 10 3 99999999 1 0
rd_high_after R 10 2 0 0 77fe56aa
err_rd_size R 14 3 0 1 00000000
seq_basic S 1 1 03020403 5 04000080
seq_no_delay S 2 1 02000205 0 7fff0001
seq_zero_as_one S 0 1 00010000 0 12345678
seq_disabled S 1 0 03020403 0 11112222
seq_rand_a S 3 1 0 0 0
seq_rand_b S 0 1 0 0 0
rd_flags_end R 04 2 0 0 00000000
